// File: files.f
verilog/armCtrlPkg.sv
verilog/instrDecoder.sv
verilog/condUnit.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/armController.sv
sim/armControllerTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= armControllerTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/armControllerTb.sv
`timescale 1ns/100ps

module armControllerTb;
  import armCtrlPkg::*;

  typedef struct {
    string      name;
    instrWordT  instr;
    flagsT      aluFlags;   // Driven while the row is in E
    int         addrLow;    // Negative means draw from the LFSR
    logic       flush;      // Driven while the row is in D
    decodeCtrlT expDecode;
  } rowT;

  logic       clk = 1'b0;
  logic       arstN;
  logic       stallE;
  logic       flushE;
  logic       stallM;
  logic       stallW;
  logic       flushW;
  instrWordT  instrD;
  flagsT      aluFlagsE;
  logic [1:0] aluAddrLowE;
  decodeCtrlT decodeCtrlD;
  aluOpE      aluControlE;
  logic       aluSrcE;
  logic       multSelectE;
  logic       branchTakenE;
  memCtrlT    memCtrlM;
  wbCtrlT     wbCtrlW;
  logic       pcWrPendingF;

  rowT        rows[$];
  decodeCtrlT expE[$];      // Expected E controls per row
  memCtrlT    expM[$];      // Expected M controls per row
  logic       expTaken[$];
  logic       tableReady = 1'b0;
  logic [31:0] lfsrState = 32'hd787_b327;

  always #10 clk = ~clk;

  armController armController_inst (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .aluAddrLowE  (aluAddrLowE),
    .decodeCtrlD  (decodeCtrlD),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .multSelectE  (multSelectE),
    .branchTakenE (branchTakenE),
    .memCtrlM     (memCtrlM),
    .wbCtrlW      (wbCtrlW),
    .pcWrPendingF (pcWrPendingF)
  );

  // ==========================================================
  // Random bits and reference rules
  // ==========================================================

  function automatic logic stepLfsr();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ 32'h8020_0003;  // Galois taps 32,22,2,1
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int width);
    logic [31:0] value;
    int i;
    value = '0;
    for (i = 0; i < width; i++)
      value = {value[30:0], stepLfsr()};
    return value;
  endfunction

  // Even codes test a flag term, odd codes invert it, so 4'hF is never taken
  function automatic logic condHolds(input logic [3:0] cond, input flagsT f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1;
    endcase
    return base ^ cond[0];
  endfunction

  function automatic decodeCtrlT expDataProc(input aluOpE op, input logic imm,
                                             input logic s, input logic pc);
    decodeCtrlT d;
    d = '0;
    d.aluSrc     = imm;
    d.regWrite   = 1'b1;
    d.setFlags   = s;
    d.pcSrc      = pc;
    d.aluControl = op;
    return d;
  endfunction

  function automatic decodeCtrlT expMul();
    decodeCtrlT d;
    d = '0;
    d.regWrite   = 1'b1;
    d.multSelect = 1'b1;
    d.aluControl = aluAdd;
    return d;
  endfunction

  function automatic decodeCtrlT expMemOp(input logic load, input logic byteAcc, input logic up);
    decodeCtrlT d;
    d = '0;
    d.regSrc     = load ? 2'b00 : 2'b10;  // Stores read Rd
    d.immSrc     = 2'b01;
    d.aluSrc     = 1'b1;
    d.memToReg   = load;
    d.regWrite   = load;
    d.memWrite   = ~load;
    d.byteAccess = byteAcc;
    d.aluControl = up ? aluAdd : aluSub;
    return d;
  endfunction

  function automatic decodeCtrlT expBranch();
    decodeCtrlT d;
    d = '0;
    d.regSrc     = 2'b01;
    d.immSrc     = 2'b10;
    d.aluSrc     = 1'b1;
    d.branch     = 1'b1;
    d.pcSrc      = 1'b1;
    d.aluControl = aluAdd;
    return d;
  endfunction

  // ==========================================================
  // Failure reporting and compare tasks
  // ==========================================================

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic checkDecode(input string name, input decodeCtrlT expected,
                             input decodeCtrlT actual);
    if (actual !== expected)
      failRun($sformatf("Error: %s decodeCtrlD expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkAluOp(input string name, input aluOpE expected, input aluOpE actual);
    if (actual !== expected)
      failRun($sformatf("Error: %s aluControlE expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkMem(input string name, input memCtrlT expected, input memCtrlT actual);
    if (actual !== expected)
      failRun($sformatf("Error: %s memCtrlM expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkWb(input string name, input wbCtrlT expected, input wbCtrlT actual);
    if (actual !== expected)
      failRun($sformatf("Error: %s wbCtrlW expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      failRun($sformatf("Error: %s expected %b actual %b", name, expected, actual));
  endtask

  // ==========================================================
  // Stimulus table
  // ==========================================================

  task automatic addRow(input string name, input instrWordT instr, input flagsT aluFlags,
                        input int addrLow, input logic flush, input decodeCtrlT expDecode);
    rowT r;
    r.name      = name;
    r.instr     = instr;
    r.aluFlags  = aluFlags;
    r.addrLow   = addrLow;
    r.flush     = flush;
    r.expDecode = expDecode;
    if (addrLow < 0)
      r.addrLow = int'(randBits(2));
    rows.push_back(r);
  endtask

  // Random register-form logic op, never r15 and never the multiply pattern
  task automatic addFiller();
    aluOpE     fillerOps[4];
    instrWordT w;
    fillerOps = '{aluAnd, aluEor, aluOrr, aluBic};
    w = '0;
    w.dpView.cond     = condAl;
    w.dpView.opcode   = fillerOps[2'(randBits(2))];
    w.dpView.rn       = 4'(randBits(4));
    w.dpView.rd       = {1'b0, 3'(randBits(3))};
    w.dpView.operand2 = {7'(randBits(7)), 1'b0, 4'(randBits(4))};
    addRow($sformatf("filler%0d", rows.size()), w, 4'b0000, -1, 1'b0,
           expDataProc(w.dpView.opcode, 1'b0, 1'b0, 1'b0));
  endtask

  task automatic buildTable();
    addRow("addImm",      32'hE282_1005, 4'b0000, -1, 1'b0, expDataProc(aluAdd, 1'b1, 1'b0, 1'b0));
    addRow("subsSetZ",    32'hE053_3003, 4'b0110, -1, 1'b0, expDataProc(aluSub, 1'b0, 1'b1, 1'b0));
    addRow("addEq",       32'h0284_4001, 4'b0000, -1, 1'b0, expDataProc(aluAdd, 1'b1, 1'b0, 1'b0));
    addRow("addNe",       32'h1285_5001, 4'b0000, -1, 1'b0, expDataProc(aluAdd, 1'b1, 1'b0, 1'b0));
    addRow("mul",         32'hE006_0897, 4'b0000, -1, 1'b0, expMul());
    addFiller();
    addRow("cmpGt",       32'hE351_0005, 4'b0010, -1, 1'b0, expDataProc(aluCmp, 1'b1, 1'b1, 1'b0));
    addRow("bgtTaken",    32'hCA00_0004, 4'b0000, -1, 1'b0, expBranch());
    addRow("bleNotTaken", 32'hDA00_0004, 4'b0000, -1, 1'b0, expBranch());
    addFiller();
    addFiller();
    addRow("ldrWord",     32'hE593_2008, 4'b0000, -1, 1'b0, expMemOp(1'b1, 1'b0, 1'b1));
    addRow("strbLane0",   32'hE5C3_2001, 4'b0000,  0, 1'b0, expMemOp(1'b0, 1'b1, 1'b1));
    addRow("strbLane1",   32'hE5C3_2001, 4'b0000,  1, 1'b0, expMemOp(1'b0, 1'b1, 1'b1));
    addRow("strbLane2",   32'hE5C3_2001, 4'b0000,  2, 1'b0, expMemOp(1'b0, 1'b1, 1'b1));
    addRow("strbLane3",   32'hE5C3_2001, 4'b0000,  3, 1'b0, expMemOp(1'b0, 1'b1, 1'b1));
    addRow("strWordDown", 32'hE503_2004, 4'b0000, -1, 1'b0, expMemOp(1'b0, 1'b0, 1'b0));
    addRow("movPc",       32'hE1A0_F00E, 4'b0000, -1, 1'b0, expDataProc(aluMov, 1'b0, 1'b0, 1'b1));
    addFiller();
    addFiller();
    addRow("strFlushed",  32'hE583_2000, 4'b0000, -1, 1'b1, expMemOp(1'b0, 1'b0, 1'b1));
    addFiller();
    addRow("branchAl",    32'hEA00_0010, 4'b0000, -1, 1'b0, expBranch());
    addFiller();
    addFiller();
    addFiller();
  endtask

  // Walks the rows in order and tracks the flags each one sees in E
  task automatic predictRows();
    flagsT      flags;
    decodeCtrlT d;
    memCtrlT    m;
    logic [3:0] opc;
    logic [1:0] lane;
    logic       ex;
    logic       isCompare;
    int         i;
    flags = '0;
    for (i = 0; i < rows.size(); i++) begin
      if (rows[i].flush)
        d = '0;                         // Bubble in E
      else
        d = rows[i].expDecode;
      opc       = rows[i].instr[24:21];
      lane      = 2'(rows[i].addrLow);
      ex        = condHolds(rows[i].instr[31:28], flags);
      isCompare = d.setFlags & (opc[3:2] == 2'b10);  // TST, TEQ, CMP, CMN
      m = '0;
      m.memWrite   = d.memWrite & ex;
      m.memToReg   = d.memToReg;
      m.regWrite   = d.regWrite & ex & ~isCompare;
      m.pcSrc      = d.pcSrc & ex;
      m.byteAccess = d.byteAccess;
      if (m.memWrite && d.byteAccess)
        m.byteMask[lane] = 1'b1;
      else if (m.memWrite)
        m.byteMask = 4'hF;
      expE.push_back(d);
      expM.push_back(m);
      expTaken.push_back(d.branch & ex);
      if (d.setFlags && ex)
        flags = rows[i].aluFlags;
    end
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    int     t;
    int     n;
    logic   pcExp;
    wbCtrlT expWb;
    arstN       = 1'b0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    stallM      = 1'b0;
    stallW      = 1'b0;
    flushW      = 1'b0;
    instrD      = '0;
    aluFlagsE   = '0;
    aluAddrLowE = 2'b00;
    buildTable();
    predictRows();
    tableReady = 1'b1;
    n = rows.size();

    repeat (5) @(negedge clk);
    checkMem("reset", '0, memCtrlM);
    checkWb("reset", '0, wbCtrlW);
    arstN = 1'b1;

    // Row t is in D, row t-1 in E, row t-2 in M, row t-3 in W
    for (t = 0; t < n + 3; t++) begin
      @(negedge clk);
      instrD      = '0;
      flushE      = 1'b0;
      aluFlagsE   = '0;
      aluAddrLowE = 2'b00;
      if (t < n) begin
        instrD = rows[t].instr;
        flushE = rows[t].flush;
      end
      if (t >= 1 && t - 1 < n) begin
        aluFlagsE   = rows[t - 1].aluFlags;
        aluAddrLowE = 2'(rows[t - 1].addrLow);
      end
      #1;
      pcExp = 1'b0;
      if (t < n) begin
        checkDecode(rows[t].name, rows[t].expDecode, decodeCtrlD);
        pcExp = rows[t].expDecode.pcSrc;
      end
      if (t >= 1 && t - 1 < n) begin
        checkAluOp(rows[t - 1].name, expE[t - 1].aluControl, aluControlE);
        checkBit({rows[t - 1].name, " aluSrcE"}, expE[t - 1].aluSrc, aluSrcE);
        checkBit({rows[t - 1].name, " multSelectE"}, expE[t - 1].multSelect, multSelectE);
        checkBit({rows[t - 1].name, " branchTakenE"}, expTaken[t - 1], branchTakenE);
        pcExp = pcExp | expM[t - 1].pcSrc;
      end
      if (t >= 2 && t - 2 < n) begin
        checkMem(rows[t - 2].name, expM[t - 2], memCtrlM);
        pcExp = pcExp | expM[t - 2].pcSrc;
      end
      if (t >= 3) begin
        expWb.memToReg = expM[t - 3].memToReg;
        expWb.regWrite = expM[t - 3].regWrite;
        expWb.pcSrc    = expM[t - 3].pcSrc;
        checkWb(rows[t - 3].name, expWb, wbCtrlW);
      end
      checkBit($sformatf("cycle%0d pcWrPendingF", t), pcExp, pcWrPendingF);
    end

    $display("Testbench passed");
    $finish;
  end

  // Reset plus one cycle per row, with margin
  initial begin
    wait (tableReady);
    #(rows.size() * 20 + 400);
    failRun("Watchdog expired before all table rows were checked");
  end

endmodule

// File: verilog/armController.sv
`timescale 1ns/100ps

module armController (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   stallE,
  input  logic                   flushE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushW,
  input  armCtrlPkg::instrWordT  instrD,
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  logic [1:0]             aluAddrLowE,
  output armCtrlPkg::decodeCtrlT decodeCtrlD,
  output armCtrlPkg::aluOpE      aluControlE,
  output logic                   aluSrcE,
  output logic                   multSelectE,
  output logic                   branchTakenE,
  output armCtrlPkg::memCtrlT    memCtrlM,
  output armCtrlPkg::wbCtrlT     wbCtrlW,
  output logic                   pcWrPendingF
);
  import armCtrlPkg::*;

  memCtrlT memCtrlE;
  flagsT   flagsNextE;
  flagsT   flagsNextM;
  flagsT   flagsNextW;
  logic    setFlagsE;
  logic    setFlagsM;

  instrDecoder instrDecoder_inst (
    .instrD      (instrD),
    .decodeCtrlD (decodeCtrlD)
  );

  executeStage executeStage_inst (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .instrD       (instrD),
    .decodeCtrlD  (decodeCtrlD),
    .aluFlagsE    (aluFlagsE),
    .aluAddrLowE  (aluAddrLowE),
    .flagsNextM   (flagsNextM),
    .flagsNextW   (flagsNextW),
    .setFlagsM    (setFlagsM),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .multSelectE  (multSelectE),
    .branchTakenE (branchTakenE),
    .setFlagsE    (setFlagsE),
    .flagsNextE   (flagsNextE),
    .memCtrlE     (memCtrlE)
  );

  memWbStage memWbStage_inst (
    .clk        (clk),
    .arstN      (arstN),
    .stallM     (stallM),
    .stallW     (stallW),
    .flushW     (flushW),
    .memCtrlE   (memCtrlE),
    .flagsNextE (flagsNextE),
    .setFlagsE  (setFlagsE),
    .memCtrlM   (memCtrlM),
    .wbCtrlW    (wbCtrlW),
    .flagsNextM (flagsNextM),
    .flagsNextW (flagsNextW),
    .setFlagsM  (setFlagsM)
  );

  // Fetch waits while any stage up to M may still redirect the PC
  assign pcWrPendingF = decodeCtrlD.pcSrc | memCtrlE.pcSrc | memCtrlM.pcSrc;

endmodule

// File: verilog/memWbStage.sv
`timescale 1ns/100ps

module memWbStage (
  input  logic                clk,
  input  logic                arstN,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushW,
  input  armCtrlPkg::memCtrlT memCtrlE,
  input  armCtrlPkg::flagsT   flagsNextE,
  input  logic                setFlagsE,
  output armCtrlPkg::memCtrlT memCtrlM,
  output armCtrlPkg::wbCtrlT  wbCtrlW,
  output armCtrlPkg::flagsT   flagsNextM,
  output armCtrlPkg::flagsT   flagsNextW,
  output logic                setFlagsM
);

  // ==========================================================
  // E to M register, hold only
  // ==========================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memCtrlM   <= '0;
      flagsNextM <= '0;
      setFlagsM  <= 1'b0;
    end else if (!stallM) begin
      memCtrlM   <= memCtrlE;
      flagsNextM <= flagsNextE;
      setFlagsM  <= setFlagsE;
    end
  end

  // ==========================================================
  // M to W register
  // ==========================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbCtrlW    <= '0;
      flagsNextW <= '0;
    end else if (flushW) begin
      wbCtrlW <= '0;  // Flags stay as they were
    end else if (!stallW) begin
      wbCtrlW <= '{
        memToReg: memCtrlM.memToReg,
        regWrite: memCtrlM.regWrite,
        pcSrc:    memCtrlM.pcSrc
      };
      flagsNextW <= flagsNextM;
    end
  end

  // Load and store are exclusive all the way from decode
  assert property (@(posedge clk) disable iff (!arstN)
    !(memCtrlM.memWrite && memCtrlM.memToReg));

  assert property (@(posedge clk) disable iff (!arstN)
    flushW |=> (wbCtrlW == '0));

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/100ps

module executeStage (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   stallE,
  input  logic                   flushE,
  input  armCtrlPkg::instrWordT  instrD,
  input  armCtrlPkg::decodeCtrlT decodeCtrlD,
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  logic [1:0]             aluAddrLowE,
  input  armCtrlPkg::flagsT      flagsNextM,
  input  armCtrlPkg::flagsT      flagsNextW,
  input  logic                   setFlagsM,
  output armCtrlPkg::aluOpE      aluControlE,
  output logic                   aluSrcE,
  output logic                   multSelectE,
  output logic                   branchTakenE,
  output logic                   setFlagsE,
  output armCtrlPkg::flagsT      flagsNextE,
  output armCtrlPkg::memCtrlT    memCtrlE
);
  import armCtrlPkg::*;

  decodeCtrlT decodeCtrlE;
  condCodeE   condE;
  aluOpE      opcodeE;
  flagsT      flagsE;
  logic       condExE;
  logic       compareE;
  logic       memWriteGatedE;
  logic [3:0] byteMaskE;

  // ==========================================================
  // D to E register
  // ==========================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decodeCtrlE <= '0;
      condE       <= condEq;
      opcodeE     <= aluAnd;
    end else if (flushE) begin  // Bubble wins over a hold
      decodeCtrlE <= '0;
      condE       <= condEq;
      opcodeE     <= aluAnd;
    end else if (!stallE) begin
      decodeCtrlE <= decodeCtrlD;
      condE       <= instrD.dpView.cond;
      opcodeE     <= instrD.dpView.opcode;
    end
  end

  // Newest flags: M if it is about to set them, else W
  assign flagsE = setFlagsM ? flagsNextM : flagsNextW;

  condUnit condUnit_inst (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .setFlags  (decodeCtrlE.setFlags),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  // TST/TEQ/CMP/CMN always carry S, loads and branches never do
  assign compareE = decodeCtrlE.setFlags & (opcodeE inside {aluTst, aluTeq, aluCmp, aluCmn});

  assign memWriteGatedE = decodeCtrlE.memWrite & condExE;

  // Lane 0 is the low byte
  always_comb begin
    if (!memWriteGatedE)
      byteMaskE = 4'h0;
    else if (decodeCtrlE.byteAccess)
      byteMaskE = 4'b0001 << aluAddrLowE;
    else
      byteMaskE = 4'hF;
  end

  assign memCtrlE = '{
    memWrite:   memWriteGatedE,
    memToReg:   decodeCtrlE.memToReg,
    regWrite:   decodeCtrlE.regWrite & condExE & ~compareE,
    pcSrc:      decodeCtrlE.pcSrc & condExE,
    byteAccess: decodeCtrlE.byteAccess,
    byteMask:   byteMaskE
  };

  assign aluControlE  = decodeCtrlE.aluControl;
  assign aluSrcE      = decodeCtrlE.aluSrc;
  assign multSelectE  = decodeCtrlE.multSelect;
  assign branchTakenE = decodeCtrlE.branch & condExE;
  assign setFlagsE    = decodeCtrlE.setFlags & condExE;

  // A taken branch redirects fetch and touches neither memory nor registers
  assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE |-> memCtrlE.pcSrc && !memCtrlE.memWrite && !memCtrlE.regWrite);

endmodule

// File: verilog/condUnit.sv
`timescale 1ns/100ps

module condUnit (
  input  armCtrlPkg::condCodeE cond,
  input  armCtrlPkg::flagsT    flags,
  input  armCtrlPkg::flagsT    aluFlags,
  input  logic                 setFlags,
  output logic                 condEx,
  output armCtrlPkg::flagsT    flagsNext
);
  import armCtrlPkg::*;

  logic signedGe;

  // N == V means signed greater or equal
  assign signedGe = (flags.n == flags.v);

  // ==========================================================
  // Condition check
  // ==========================================================

  always_comb begin
    case (cond)
      condEq:  condEx = flags.z;
      condNe:  condEx = ~flags.z;
      condCs:  condEx = flags.c;
      condCc:  condEx = ~flags.c;
      condMi:  condEx = flags.n;
      condPl:  condEx = ~flags.n;
      condVs:  condEx = flags.v;
      condVc:  condEx = ~flags.v;
      condHi:  condEx = flags.c & ~flags.z;   // Unsigned higher
      condLs:  condEx = ~flags.c | flags.z;
      condGe:  condEx = signedGe;
      condLt:  condEx = ~signedGe;
      condGt:  condEx = ~flags.z & signedGe;
      condLe:  condEx = flags.z | ~signedGe;
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;                 // Reserved code never executes
    endcase
  end

  // Flags only move for an executed S instruction
  assign flagsNext = (setFlags & condEx) ? aluFlags : flags;

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
  input  armCtrlPkg::instrWordT  instrD,
  output armCtrlPkg::decodeCtrlT decodeCtrlD
);
  import armCtrlPkg::*;

  logic isDataProc;
  logic isMult;
  logic isMem;
  logic isBranch;

  // ==========================================================
  // Instruction class
  // ==========================================================

  // MUL has the 1001 pattern in bits 7:4 and bit 24 clear
  assign isMult = (instrD.dpView.op == 2'b00) & ~instrD.dpView.immFlag &
                  (instrD.dpView.operand2[7:4] == 4'b1001) & ~instrD[24];

  assign isDataProc = (instrD.dpView.op == 2'b00) & ~isMult;
  assign isMem      = (instrD.memView.op == 2'b01);
  assign isBranch   = (instrD.dpView.op == 2'b10);

  // ==========================================================
  // Control fields
  // ==========================================================

  always_comb begin
    decodeCtrlD = '0;  // Class 11 and anything unknown decode as a bubble

    if (isDataProc) begin
      decodeCtrlD.aluSrc     = instrD.dpView.immFlag;  // Rotated immediate
      decodeCtrlD.regWrite   = 1'b1;
      decodeCtrlD.setFlags   = instrD.dpView.setFlags;
      decodeCtrlD.aluControl = instrD.dpView.opcode;
    end else if (isMult) begin
      decodeCtrlD.regWrite   = 1'b1;
      decodeCtrlD.multSelect = 1'b1;
      decodeCtrlD.setFlags   = instrD.dpView.setFlags;
      decodeCtrlD.aluControl = aluAdd;
    end else if (isMem) begin
      // Stores read Rd as the data operand
      decodeCtrlD.regSrc     = {~instrD.memView.load, 1'b0};
      decodeCtrlD.immSrc     = 2'b01;                      // 12-bit offset
      decodeCtrlD.aluSrc     = ~instrD.memView.regOffset;
      decodeCtrlD.memToReg   = instrD.memView.load;
      decodeCtrlD.regWrite   = instrD.memView.load;
      decodeCtrlD.memWrite   = ~instrD.memView.load;
      decodeCtrlD.byteAccess = instrD.memView.byteAccess;
      decodeCtrlD.aluControl = instrD.memView.up ? aluAdd : aluSub;
    end else if (isBranch) begin
      decodeCtrlD.regSrc     = 2'b01;  // PC as first operand
      decodeCtrlD.immSrc     = 2'b10;  // 24-bit word offset
      decodeCtrlD.aluSrc     = 1'b1;
      decodeCtrlD.branch     = 1'b1;
      decodeCtrlD.aluControl = aluAdd;
    end

    // Writing r15 redirects fetch just like a branch
    decodeCtrlD.pcSrc = ((instrD.dpView.rd == pcRegNum) & decodeCtrlD.regWrite) |
                        decodeCtrlD.branch;
  end

endmodule

// File: verilog/armCtrlPkg.sv
package armCtrlPkg;

  // ==========================================================
  // Encodings
  // ==========================================================

  // Condition field, 4'hF is reserved and left unnamed
  typedef enum logic [3:0] {
    condEq = 4'h0,
    condNe = 4'h1,
    condCs = 4'h2,
    condCc = 4'h3,
    condMi = 4'h4,
    condPl = 4'h5,
    condVs = 4'h6,
    condVc = 4'h7,
    condHi = 4'h8,
    condLs = 4'h9,
    condGe = 4'hA,
    condLt = 4'hB,
    condGt = 4'hC,
    condLe = 4'hD,
    condAl = 4'hE
  } condCodeE;

  // Data-processing opcodes as the ALU sees them
  typedef enum logic [3:0] {
    aluAnd = 4'h0,
    aluEor = 4'h1,
    aluSub = 4'h2,  // Also loads/stores with U clear
    aluRsb = 4'h3,
    aluAdd = 4'h4,  // Loads/stores with U set, branches, multiply
    aluAdc = 4'h5,
    aluSbc = 4'h6,
    aluRsc = 4'h7,
    aluTst = 4'h8,
    aluTeq = 4'h9,
    aluCmp = 4'hA,
    aluCmn = 4'hB,
    aluOrr = 4'hC,
    aluMov = 4'hD,
    aluBic = 4'hE,
    aluMvn = 4'hF
  } aluOpE;

  localparam logic [3:0] pcRegNum = 4'd15;

  // ==========================================================
  // Instruction word, seen two ways
  // ==========================================================

  typedef struct packed {
    condCodeE    cond;
    logic [1:0]  op;
    logic        immFlag;
    aluOpE       opcode;
    logic        setFlags;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpViewT;

  typedef struct packed {
    condCodeE    cond;
    logic [1:0]  op;
    logic        regOffset;
    logic        preIndex;
    logic        up;
    logic        byteAccess;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memViewT;

  typedef union packed {
    dpViewT  dpView;
    memViewT memView;
  } instrWordT;

  // ==========================================================
  // Control bundles per stage
  // ==========================================================

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       setFlags;
    logic       pcSrc;
    logic       byteAccess;
    logic       multSelect;
    aluOpE      aluControl;
  } decodeCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic       byteAccess;
    logic [3:0] byteMask;
  } memCtrlT;

  typedef struct packed {
    logic memToReg;
    logic regWrite;
    logic pcSrc;
  } wbCtrlT;

endpackage
